/* design/l2_tlb_pkg.sv */
package l2_tlb_pkg;

    // sv32 address widths.
    localparam int vaddr_w = 32;
    localparam int paddr_w = 34;
    localparam int page_offset_w = 12;
    localparam int vpn_w = 10;
    localparam int pte_w = 32;

    // tlb geometry.
    localparam int line_ptes = 4;
    localparam int line_off_w = 2;
    localparam int l0_sets = 16;
    localparam int l1_sets = 8;
    localparam int num_levels = 2;

    typedef struct packed {
        logic [11:0] ppn1;
        logic [9:0]  ppn0;
        logic [1:0]  rsw;
        logic        d;
        logic        a;
        logic        g;
        logic        u;
        logic        x;
        logic        w;
        logic        r;
        logic        v;
    } pte_t;

    // one refill line, pte 0 in the low bits.
    typedef pte_t [line_ptes-1:0] pte_line_t;

    typedef enum logic [1:0] {
        fetch = 2'd0,
        load  = 2'd1,
        store = 2'd2
    } access_t;

    typedef logic [vaddr_w-1:0] vaddr_t;
    typedef logic [paddr_w-1:0] paddr_t;

endpackage

/* design/tlb_sram.sv */
`timescale 1ns/10ps

module tlb_sram #(
    parameter type data_t = logic,
    parameter int depth = 16
) (
    input  logic                     clk,
    input  logic                     en,
    input  logic                     we,
    input  logic [$clog2(depth)-1:0] addr,
    input  data_t                    wdata,
    output data_t                    rdata
);

    data_t mem [depth];

    // contents power up cleared, so valid bits start low.
    initial begin
        for (int i = 0; i < depth; i++) begin
            mem[i] = '0;
        end
    end

    // write has priority, read data lands one cycle after en.
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end else begin
                rdata <= mem[addr];
            end
        end
    end

    a_addr_in_range: assert property (@(posedge clk) en |-> (addr < depth))
        else $error("tlb_sram address %0d out of range", addr);

endmodule

/* design/tlb_perm_check.sv */
`timescale 1ns/10ps

module tlb_perm_check (
    input  l2_tlb_pkg::pte_t    entry,
    input  l2_tlb_pkg::access_t access,
    input  logic [1:0]          csr_mode,
    input  logic                csr_sum,
    input  logic                csr_mxr,
    output logic                exception
);

    import l2_tlb_pkg::*;

    logic leaf;
    logic format_fail;
    logic perm_ok;
    logic priv_fail;
    logic ad_fail;

    assign leaf = entry.r | entry.w | entry.x;

    // reserved encodings.
    assign format_fail = ~entry.v | (entry.w & ~entry.r) | (|entry.rsw);

    always_comb begin
        case (access)
            fetch:   perm_ok = entry.x;
            load:    perm_ok = entry.r | (entry.x & csr_mxr);
            store:   perm_ok = entry.w;
            default: perm_ok = 1'b0;
        endcase
    end

    // mode 0 is user, mode 1 supervisor.
    assign priv_fail = ((csr_mode == 2'd1) & entry.u & ~csr_sum) |
                       ((csr_mode == 2'd0) & ~entry.u);

    // no hardware a/d update, the walker must set them.
    assign ad_fail = ~entry.a | ((access == store) & ~entry.d);

    assign exception = format_fail | (leaf & (~perm_ok | priv_fail | ad_fail));

endmodule

/* design/tlb_paddr_gen.sv */
`timescale 1ns/10ps

module tlb_paddr_gen #(
    parameter int level = 0
) (
    input  l2_tlb_pkg::pte_t   entry,
    input  l2_tlb_pkg::vaddr_t vaddr,
    output l2_tlb_pkg::paddr_t paddr
);

    import l2_tlb_pkg::*;

    generate
        if (level == 0) begin : g_page
            assign paddr = {entry.ppn1, entry.ppn0, vaddr[page_offset_w-1:0]};
        end else begin : g_mega
            logic             leaf;
            logic [vpn_w-1:0] vpn0;

            assign leaf = entry.r | entry.w | entry.x;
            assign vpn0 = vaddr[page_offset_w +: vpn_w];

            // leaf gives a megapage address, a pointer gives the next pte address.
            assign paddr = leaf ? {entry.ppn1, vpn0, vaddr[page_offset_w-1:0]}
                                : {entry[pte_w-1:10], vpn0, 2'b00};
        end
    endgenerate

endmodule

/* design/tlb_page.sv */
`timescale 1ns/10ps

module tlb_page #(
    parameter int level = 0,
    parameter int sets = 16
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req,
    input  logic                  flush,
    input  l2_tlb_pkg::vaddr_t    vaddr,
    input  logic                  refill_req,
    input  logic                  refill_write,
    input  l2_tlb_pkg::vaddr_t    refill_vaddr,
    input  l2_tlb_pkg::pte_line_t refill_data,
    input  logic                  fence_valid,
    input  logic                  fence_all,
    input  l2_tlb_pkg::vaddr_t    fence_vaddr,
    output logic                  hit,
    output l2_tlb_pkg::pte_t      entry,
    output logic                  unaligned,
    output logic                  fence_done
);

    import l2_tlb_pkg::*;

    localparam int idx_w = $clog2(sets);
    localparam int off_lo = page_offset_w + level * vpn_w;
    localparam int idx_lo = off_lo + line_off_w;
    localparam int tag_w = vpn_w * (num_levels - level) - line_off_w - idx_w;

    typedef struct packed {
        logic                 valid;
        logic [line_ptes-1:0] unaligned;
        logic [tag_w-1:0]     tag;
    } tag_entry_t;

    typedef enum logic [1:0] {
        st_idle,
        st_fence,
        st_fence_all,
        st_end
    } fence_state_t;

    fence_state_t         state;
    logic                 fence_rd;
    logic                 fence_we;
    logic [idx_w-1:0]     fence_idx;
    logic [tag_w-1:0]     fence_tag_q;
    logic                 fence_match;

    logic                 req_q;
    logic [line_off_w-1:0] off_q;
    logic [tag_w-1:0]     tag_q;

    logic                 refill_wr;
    logic [line_ptes-1:0] refill_unaligned;
    logic [idx_w-1:0]     ram_idx;
    logic                 tag_en;
    logic                 tag_we;
    tag_entry_t           tag_wdata;
    tag_entry_t           tag_rdata;
    logic                 data_en;
    pte_line_t            data_rdata;

    function automatic logic [idx_w-1:0] set_of(vaddr_t va);
        return va[idx_lo +: idx_w];
    endfunction

    function automatic logic [tag_w-1:0] tag_of(vaddr_t va);
        return va[vaddr_w-1 -: tag_w];
    endfunction

    assign refill_wr = refill_req & refill_write;

    // only megapage leaves can be misaligned.
    generate
        for (genvar i = 0; i < line_ptes; i++) begin : g_unaligned
            if (level == 1) begin : g_check
                assign refill_unaligned[i] = (refill_data[i].ppn0 != '0) &
                    (refill_data[i].r | refill_data[i].w | refill_data[i].x);
            end else begin : g_none
                assign refill_unaligned[i] = 1'b0;
            end
        end
    endgenerate

    // fence beats refill beats lookup.
    assign ram_idx = (fence_rd | fence_we) ? fence_idx :
                     refill_req            ? set_of(refill_vaddr) :
                                             set_of(vaddr);

    assign tag_en = req | refill_wr | fence_rd | fence_we;
    assign tag_we = refill_wr | fence_we;
    assign tag_wdata = fence_we ? '0 : {1'b1, refill_unaligned, tag_of(refill_vaddr)};
    assign data_en = req | refill_wr;

    tlb_sram #(
        .data_t(tag_entry_t),
        .depth (sets)
    ) u_tag_ram (
        .clk  (clk),
        .en   (tag_en),
        .we   (tag_we),
        .addr (ram_idx),
        .wdata(tag_wdata),
        .rdata(tag_rdata)
    );

    tlb_sram #(
        .data_t(pte_line_t),
        .depth (sets)
    ) u_data_ram (
        .clk  (clk),
        .en   (data_en),
        .we   (refill_wr),
        .addr (ram_idx),
        .wdata(refill_data),
        .rdata(data_rdata)
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            req_q <= 1'b0;
        end else begin
            req_q <= req & ~flush;
        end
    end

    always_ff @(posedge clk) begin
        off_q <= vaddr[off_lo +: line_off_w];
        tag_q <= tag_of(vaddr);
    end

    assign hit = req_q & tag_rdata.valid & (tag_rdata.tag == tag_q);
    assign entry = data_rdata[off_q];
    assign unaligned = tag_rdata.unaligned[off_q];

    assign fence_match = tag_rdata.valid & (tag_rdata.tag == fence_tag_q);

    always_ff @(posedge clk) begin
        if (state == st_idle) begin
            fence_tag_q <= tag_of(fence_vaddr);
        end
    end

    // single fence: read, compare, clear. fence all sweeps every set.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_idle;
            fence_rd <= 1'b0;
            fence_we <= 1'b0;
            fence_idx <= '0;
            fence_done <= 1'b0;
        end else begin
            fence_done <= (state == st_end);
            case (state)
                st_idle: begin
                    if (fence_valid) begin
                        fence_idx <= fence_all ? '0 : set_of(fence_vaddr);
                        fence_rd <= ~fence_all;
                        fence_we <= fence_all;
                        state <= fence_all ? st_fence_all : st_fence;
                    end
                end
                st_fence: begin
                    fence_rd <= 1'b0;
                    // tag data is valid once the read strobe has dropped.
                    if (!fence_rd) begin
                        fence_we <= fence_match;
                        state <= st_end;
                    end
                end
                st_fence_all: begin
                    fence_idx <= fence_idx + 1'b1;
                    if (fence_idx == idx_w'(sets - 1)) begin
                        fence_we <= 1'b0;
                        state <= st_end;
                    end
                end
                default: begin
                    fence_we <= 1'b0;
                    state <= st_idle;
                end
            endcase
        end
    end

    a_no_refill_in_fence: assert property (
        @(posedge clk) disable iff (rst) (state != st_idle) |-> !refill_req
    ) else $error("refill during fence at level %0d", level);

endmodule

/* design/l2_tlb.sv */
`timescale 1ns/10ps

module l2_tlb (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic                                     req,
    input  l2_tlb_pkg::vaddr_t                       vaddr,
    input  l2_tlb_pkg::access_t                      access,
    input  logic                                     flush,
    input  logic [1:0]                               csr_mode,
    input  logic                                     csr_sum,
    input  logic                                     csr_mxr,
    input  logic                                     fence_valid,
    input  logic                                     fence_all,
    input  l2_tlb_pkg::vaddr_t                       fence_vaddr,
    output logic                                     resp_valid,
    output logic                                     resp_exception,
    output logic                                     resp_error,
    output l2_tlb_pkg::pte_t                         resp_entry,
    output l2_tlb_pkg::vaddr_t                       resp_vaddr,
    output logic                                     resp_level,
    output logic                                     fence_done,
    output logic                                     ptw_req,
    output l2_tlb_pkg::vaddr_t                       ptw_vaddr,
    output l2_tlb_pkg::access_t                      ptw_access,
    output logic [l2_tlb_pkg::num_levels-1:0]        ptw_hit_level,
    output l2_tlb_pkg::paddr_t                       ptw_next_addr,
    input  logic                                     ptw_full,
    input  logic                                     refill_req,
    input  logic [l2_tlb_pkg::num_levels-1:0]        refill_level,
    input  l2_tlb_pkg::vaddr_t                       refill_vaddr,
    input  l2_tlb_pkg::pte_line_t                    refill_data
);

    import l2_tlb_pkg::*;

    logic                          req_q;
    logic                          err_q;
    vaddr_t                        vaddr_q;
    access_t                       access_q;

    logic [num_levels-1:0]         hit;
    pte_t [num_levels-1:0]         entry;
    logic [num_levels-1:0]         unaligned;
    logic [num_levels-1:0]         perm_exc;
    logic [num_levels-1:0]         leaf;
    logic [num_levels-1:0]         exception;
    logic [num_levels-1:0]         done;
    logic [num_levels-1:0]         pointer;
    paddr_t [num_levels-1:0]       paddr;

    logic                          any_done;
    pte_t                          sel_entry;
    logic                          sel_exc;
    paddr_t                        next_addr;

    // request buffer, refill in the same cycle steals the ram port.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            req_q <= 1'b0;
            err_q <= 1'b0;
        end else begin
            req_q <= req & ~flush;
            err_q <= req & refill_req;
        end
    end

    always_ff @(posedge clk) begin
        vaddr_q <= vaddr;
        access_q <= access;
    end

    tlb_page #(
        .level(0),
        .sets (l0_sets)
    ) u_page0 (
        .clk         (clk),
        .rst         (rst),
        .req         (req),
        .flush       (flush),
        .vaddr       (vaddr),
        .refill_req  (refill_req),
        .refill_write(refill_level[0]),
        .refill_vaddr(refill_vaddr),
        .refill_data (refill_data),
        .fence_valid (fence_valid),
        .fence_all   (fence_all),
        .fence_vaddr (fence_vaddr),
        .hit         (hit[0]),
        .entry       (entry[0]),
        .unaligned   (unaligned[0]),
        .fence_done  (fence_done)
    );

    // level 1 has fewer sets and always finishes its fence first.
    tlb_page #(
        .level(1),
        .sets (l1_sets)
    ) u_page1 (
        .clk         (clk),
        .rst         (rst),
        .req         (req),
        .flush       (flush),
        .vaddr       (vaddr),
        .refill_req  (refill_req),
        .refill_write(refill_level[1]),
        .refill_vaddr(refill_vaddr),
        .refill_data (refill_data),
        .fence_valid (fence_valid),
        .fence_all   (fence_all),
        .fence_vaddr (fence_vaddr),
        .hit         (hit[1]),
        .entry       (entry[1]),
        .unaligned   (unaligned[1]),
        .fence_done  ()
    );

    generate
        for (genvar lv = 0; lv < num_levels; lv++) begin : g_level
            tlb_perm_check u_perm (
                .entry    (entry[lv]),
                .access   (access_q),
                .csr_mode (csr_mode),
                .csr_sum  (csr_sum),
                .csr_mxr  (csr_mxr),
                .exception(perm_exc[lv])
            );

            tlb_paddr_gen #(
                .level(lv)
            ) u_paddr (
                .entry(entry[lv]),
                .vaddr(vaddr_q),
                .paddr(paddr[lv])
            );

            assign leaf[lv] = entry[lv].r | entry[lv].w | entry[lv].x;
            assign exception[lv] = perm_exc[lv] | (leaf[lv] & unaligned[lv]);
        end
    endgenerate

    // a hit ends the lookup when it is a leaf or faults.
    assign done = hit & (leaf | exception);
    assign pointer = hit & ~leaf & ~exception;
    assign any_done = |done;

    // higher level wins.
    assign sel_entry = done[1] ? entry[1] : entry[0];
    assign sel_exc = done[1] ? exception[1] : exception[0];
    assign next_addr = pointer[1] ? paddr[1] : paddr[0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            resp_valid <= 1'b0;
            ptw_req <= 1'b0;
        end else begin
            resp_valid <= req_q & ~flush & (err_q | any_done | ptw_full);
            ptw_req <= req_q & ~flush & ~err_q & ~any_done & ~ptw_full;
        end
    end

    always_ff @(posedge clk) begin
        resp_exception <= ~err_q & any_done & sel_exc;
        resp_error <= err_q | (~any_done & ptw_full);
        resp_entry <= sel_entry;
        resp_vaddr <= vaddr_q;
        resp_level <= done[1];
        ptw_vaddr <= vaddr_q;
        ptw_access <= access_q;
        ptw_hit_level <= pointer;
        ptw_next_addr <= next_addr;
    end

    a_resp_or_walk: assert property (
        @(posedge clk) disable iff (rst) !(resp_valid && ptw_req)
    ) else $error("resp_valid and ptw_req pulsed together");

endmodule

/* dv/l2_tlb_tb.sv */
`timescale 1ns/10ps

module l2_tlb_tb;

    import l2_tlb_pkg::*;

    typedef struct packed {
        logic                  valid;
        logic                  ptw;
        logic                  error;
        logic                  exc;
        logic                  level;
        pte_t                  entry;
        logic [num_levels-1:0] hit_level;
        paddr_t                next;
        vaddr_t                va;
        access_t               acc;
    } expect_t;

    localparam int n_ops = 64;

    logic clk = 1'b0;
    logic rst;
    logic req;
    vaddr_t vaddr;
    access_t access;
    logic flush;
    logic [1:0] csr_mode;
    logic csr_sum;
    logic csr_mxr;
    logic fence_valid;
    logic fence_all;
    vaddr_t fence_vaddr;
    logic resp_valid;
    logic resp_exception;
    logic resp_error;
    pte_t resp_entry;
    vaddr_t resp_vaddr;
    logic resp_level;
    logic fence_done;
    logic ptw_req;
    vaddr_t ptw_vaddr;
    access_t ptw_access;
    logic [num_levels-1:0] ptw_hit_level;
    paddr_t ptw_next_addr;
    logic ptw_full;
    logic refill_req;
    logic [num_levels-1:0] refill_level;
    vaddr_t refill_vaddr;
    pte_line_t refill_data;

    // reference tables, one entry per set.
    logic l0_valid [l0_sets];
    logic [13:0] l0_tag [l0_sets];
    pte_line_t l0_line [l0_sets];
    logic l1_valid [l1_sets];
    logic [4:0] l1_tag [l1_sets];
    pte_line_t l1_line [l1_sets];

    logic [31:0] lfsr = 32'h925b;
    int errors = 0;
    vaddr_t bases [$];
    logic fence_busy = 1'b0;

    // expected response travels with the request for two cycles.
    logic chk = 1'b0;
    logic chk_q1 = 1'b0;
    logic chk_q2 = 1'b0;
    expect_t exp_r = '0;
    expect_t exp_q1 = '0;
    expect_t exp_q2 = '0;
    string exp_name = "";
    string name_q1 = "";
    string name_q2 = "";

    always #5 clk = ~clk;

    l2_tlb u_l2_tlb (.*);

    always @(posedge clk) begin
        chk_q1 <= chk;
        chk_q2 <= chk_q1;
        exp_q1 <= exp_r;
        exp_q2 <= exp_q1;
        name_q1 <= exp_name;
        name_q2 <= name_q1;
    end

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val = {val[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return val;
    endfunction

    function automatic pte_t leaf_pte(input logic mega);
        pte_t p;
        p = '0;
        p.ppn1 = 12'(rand_bits(12));
        p.ppn0 = mega ? 10'd0 : 10'(rand_bits(10));
        p.d = 1'b1;
        p.a = 1'b1;
        p.g = 1'(rand_bits(1));
        p.x = 1'(rand_bits(1));
        p.w = 1'(rand_bits(1));
        p.r = 1'b1;
        p.v = 1'b1;
        return p;
    endfunction

    function automatic pte_line_t leaf_line(input logic mega);
        pte_line_t line;
        for (int i = 0; i < line_ptes; i++) begin
            line[i] = leaf_pte(mega);
        end
        return line;
    endfunction

    function automatic pte_t pointer_pte();
        pte_t p;
        p = '0;
        p.ppn1 = 12'(rand_bits(12));
        p.ppn0 = 10'(rand_bits(10));
        p.v = 1'b1;
        return p;
    endfunction

    function automatic vaddr_t l0_addr(input vaddr_t base, input int off);
        vaddr_t va;
        va = base;
        va[13:12] = off[1:0];
        va[11:0] = 12'(rand_bits(12));
        return va;
    endfunction

    function automatic vaddr_t l1_addr(input vaddr_t base, input int off);
        vaddr_t va;
        va = base;
        va[23:22] = off[1:0];
        va[21:0] = 22'(rand_bits(22));
        return va;
    endfunction

    // sv32 index fields per level.
    function automatic logic [3:0] set0(input vaddr_t va);
        return va[17:14];
    endfunction

    function automatic logic [13:0] tag0(input vaddr_t va);
        return va[31:18];
    endfunction

    function automatic logic [2:0] set1(input vaddr_t va);
        return va[26:24];
    endfunction

    function automatic logic [4:0] tag1(input vaddr_t va);
        return va[31:27];
    endfunction

    function automatic logic perm_fault(input pte_t p, input access_t acc);
        logic leaf;
        logic allowed;
        logic bad;
        leaf = p.r | p.w | p.x;
        bad = !p.v || (p.w && !p.r) || (p.rsw != 2'b00);
        case (acc)
            fetch: allowed = p.x;
            load: allowed = p.r || (p.x && csr_mxr);
            default: allowed = p.w;
        endcase
        if (leaf) begin
            if (!allowed || !p.a || (acc == store && !p.d)) bad = 1'b1;
            if (csr_mode == 2'd1 && p.u && !csr_sum) bad = 1'b1;
            if (csr_mode == 2'd0 && !p.u) bad = 1'b1;
        end
        return bad;
    endfunction

    function automatic expect_t predict(input vaddr_t va, input access_t acc,
                                        input logic full, input logic collide);
        expect_t e;
        pte_t p0;
        pte_t p1;
        logic h0;
        logic h1;
        logic lf0;
        logic lf1;
        logic x0;
        logic x1;
        e = '0;
        e.va = va;
        e.acc = acc;
        p0 = l0_line[set0(va)][va[13:12]];
        p1 = l1_line[set1(va)][va[23:22]];
        h0 = l0_valid[set0(va)] && (l0_tag[set0(va)] == tag0(va));
        h1 = l1_valid[set1(va)] && (l1_tag[set1(va)] == tag1(va));
        lf0 = p0.r | p0.w | p0.x;
        lf1 = p1.r | p1.w | p1.x;
        x0 = perm_fault(p0, acc);
        // megapage leaves must be aligned.
        x1 = perm_fault(p1, acc) | (lf1 && p1.ppn0 != '0);
        if (collide) begin
            e.valid = 1'b1;
            e.error = 1'b1;
        end else if (h1 && (lf1 || x1)) begin
            e.valid = 1'b1;
            e.level = 1'b1;
            e.entry = p1;
            e.exc = x1;
        end else if (h0 && (lf0 || x0)) begin
            e.valid = 1'b1;
            e.entry = p0;
            e.exc = x0;
        end else if (full) begin
            e.valid = 1'b1;
            e.error = 1'b1;
        end else begin
            e.ptw = 1'b1;
            e.hit_level = {h1, h0};
            e.next = {p1.ppn1, p1.ppn0, va[21:12], 2'b00};
        end
        return e;
    endfunction

    function automatic void store_line(input logic [1:0] lv, input vaddr_t va,
                                       input pte_line_t line);
        if (lv[0]) begin
            l0_valid[set0(va)] = 1'b1;
            l0_tag[set0(va)] = tag0(va);
            l0_line[set0(va)] = line;
        end
        if (lv[1]) begin
            l1_valid[set1(va)] = 1'b1;
            l1_tag[set1(va)] = tag1(va);
            l1_line[set1(va)] = line;
        end
    endfunction

    function automatic void fence_ref(input logic all, input vaddr_t va);
        if (all) begin
            for (int i = 0; i < l0_sets; i++) l0_valid[i] = 1'b0;
            for (int i = 0; i < l1_sets; i++) l1_valid[i] = 1'b0;
        end else begin
            if (l0_tag[set0(va)] == tag0(va)) l0_valid[set0(va)] = 1'b0;
            if (l1_tag[set1(va)] == tag1(va)) l1_valid[set1(va)] = 1'b0;
        end
    endfunction

    task automatic fail_value(input string field, input logic [63:0] expv,
                              input logic [63:0] actv);
        errors++;
        $display("[FAIL] %s: %s expected %0h actual %0h", name_q2, field, expv, actv);
    endtask

    task automatic count_error(input string msg);
        errors++;
        $display("error: %s", msg);
    endtask

    task automatic set_csr(input logic [1:0] mode, input logic sum, input logic mxr);
        @(posedge clk);
        csr_mode <= mode;
        csr_sum <= sum;
        csr_mxr <= mxr;
    endtask

    // walker side, writes one line into the levels given one-hot.
    task automatic refill_line(input logic [1:0] lv, input vaddr_t va, input pte_line_t line);
        @(posedge clk);
        refill_req <= 1'b1;
        refill_level <= lv;
        refill_vaddr <= va;
        refill_data <= line;
        store_line(lv, va, line);
        bases.push_back(va);
        @(posedge clk);
        refill_req <= 1'b0;
    endtask

    task automatic lookup(input string name, input vaddr_t va, input access_t acc,
                          input logic full, input logic collide);
        @(posedge clk);
        req <= 1'b1;
        vaddr <= va;
        access <= acc;
        ptw_full <= full;
        refill_req <= collide;
        chk <= 1'b1;
        exp_r <= predict(va, acc, full, collide);
        exp_name <= name;
        if (collide) store_line(refill_level, refill_vaddr, refill_data);
        @(posedge clk);
        req <= 1'b0;
        refill_req <= 1'b0;
        chk <= 1'b0;
        // walker full is sampled with the buffered request.
        @(posedge clk);
        ptw_full <= 1'b0;
    endtask

    task automatic run_fence(input logic all, input vaddr_t va);
        int n;
        int lat;
        lat = all ? l0_sets + 2 : 4;
        @(posedge clk);
        fence_valid <= 1'b1;
        fence_all <= all;
        fence_vaddr <= va;
        fence_busy <= 1'b1;
        fence_ref(all, va);
        n = 0;
        do begin
            @(posedge clk);
            fence_valid <= 1'b0;
            n++;
        end while (!fence_done && n < 4 * lat);
        fence_busy <= 1'b0;
        if (!fence_done) begin
            count_error($sformatf("fence_done missing after %0d cycles", n));
        end else begin
            a_fence_time: assert (n == lat + 1)
                else begin
                    errors++;
                    $display("[FAIL] %s: fence_done latency expected %0d actual %0d",
                             all ? "fence_all" : "fence_addr", lat, n - 1);
                end
        end
    endtask

    a_resp_valid: assert property (@(posedge clk) disable iff (rst)
        chk_q2 |-> resp_valid == exp_q2.valid)
        else fail_value("resp_valid", $sampled(exp_q2.valid), $sampled(resp_valid));

    a_ptw_req: assert property (@(posedge clk) disable iff (rst)
        chk_q2 |-> ptw_req == exp_q2.ptw)
        else fail_value("ptw_req", $sampled(exp_q2.ptw), $sampled(ptw_req));

    a_quiet: assert property (@(posedge clk) disable iff (rst)
        !chk_q2 |-> !resp_valid && !ptw_req)
        else count_error("response or walker request without a lookup");

    a_fence_quiet: assert property (@(posedge clk) disable iff (rst)
        !fence_busy |-> !fence_done)
        else count_error("fence_done pulsed with no fence running");

    a_error: assert property (@(posedge clk) disable iff (rst)
        chk_q2 && exp_q2.valid |-> resp_error == exp_q2.error)
        else fail_value("resp_error", $sampled(exp_q2.error), $sampled(resp_error));

    a_exception: assert property (@(posedge clk) disable iff (rst)
        chk_q2 && exp_q2.valid && !exp_q2.error |-> resp_exception == exp_q2.exc)
        else fail_value("resp_exception", $sampled(exp_q2.exc), $sampled(resp_exception));

    a_entry: assert property (@(posedge clk) disable iff (rst)
        chk_q2 && exp_q2.valid && !exp_q2.error |-> resp_entry == exp_q2.entry)
        else fail_value("resp_entry", $sampled(exp_q2.entry), $sampled(resp_entry));

    a_level: assert property (@(posedge clk) disable iff (rst)
        chk_q2 && exp_q2.valid && !exp_q2.error |-> resp_level == exp_q2.level)
        else fail_value("resp_level", $sampled(exp_q2.level), $sampled(resp_level));

    a_vaddr: assert property (@(posedge clk) disable iff (rst)
        chk_q2 |-> (exp_q2.valid ? resp_vaddr : ptw_vaddr) == exp_q2.va)
        else fail_value("vaddr", $sampled(exp_q2.va),
                        $sampled(exp_q2.valid ? resp_vaddr : ptw_vaddr));

    a_ptw_access: assert property (@(posedge clk) disable iff (rst)
        chk_q2 && exp_q2.ptw |-> ptw_access == exp_q2.acc)
        else fail_value("ptw_access", $sampled(exp_q2.acc), $sampled(ptw_access));

    a_hit_level: assert property (@(posedge clk) disable iff (rst)
        chk_q2 && exp_q2.ptw |-> ptw_hit_level == exp_q2.hit_level)
        else fail_value("ptw_hit_level", $sampled(exp_q2.hit_level),
                        $sampled(ptw_hit_level));

    a_next_addr: assert property (@(posedge clk) disable iff (rst)
        chk_q2 && exp_q2.ptw && exp_q2.hit_level[1] |-> ptw_next_addr == exp_q2.next)
        else fail_value("ptw_next_addr", $sampled(exp_q2.next), $sampled(ptw_next_addr));

    initial begin
        repeat (200 * n_ops) @(posedge clk);
        $display("watchdog expired after %0d cycles, %0d errors", 200 * n_ops, errors);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        vaddr_t base;
        vaddr_t other;
        pte_line_t line;
        rst = 1'b1;
        req = 1'b0;
        vaddr = '0;
        access = load;
        flush = 1'b0;
        csr_mode = 2'd1;
        csr_sum = 1'b0;
        csr_mxr = 1'b0;
        fence_valid = 1'b0;
        fence_all = 1'b0;
        fence_vaddr = '0;
        ptw_full = 1'b0;
        refill_req = 1'b0;
        refill_level = '0;
        refill_vaddr = '0;
        refill_data = '0;
        for (int i = 0; i < l0_sets; i++) l0_valid[i] = 1'b0;
        for (int i = 0; i < l1_sets; i++) l1_valid[i] = 1'b0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        lookup("empty_miss", rand_bits(32), fetch, 1'b0, 1'b0);

        base = rand_bits(32);
        refill_line(2'b01, base, leaf_line(1'b0));
        for (int i = 0; i < line_ptes; i++) begin
            lookup("l0_hit", l0_addr(base, i), load, 1'b0, 1'b0);
        end
        lookup("full_miss", base ^ 32'h0000_4000, load, 1'b1, 1'b0);

        // megapage line with one misaligned leaf.
        base = rand_bits(32);
        line = leaf_line(1'b1);
        line[2].ppn0 = 10'(rand_bits(10)) | 10'd1;
        refill_line(2'b10, base, line);
        for (int i = 0; i < line_ptes; i++) begin
            lookup("l1_hit", l1_addr(base, i), load, 1'b0, 1'b0);
        end

        // clean page, s page, u page, x-only page.
        base = rand_bits(32);
        line = leaf_line(1'b0);
        line[0].w = 1'b1;
        line[0].d = 1'b0;
        line[2].u = 1'b1;
        line[3].r = 1'b0;
        line[3].w = 1'b0;
        line[3].x = 1'b1;
        refill_line(2'b01, base, line);
        lookup("store_clean", l0_addr(base, 0), store, 1'b0, 1'b0);
        lookup("load_clean", l0_addr(base, 0), load, 1'b0, 1'b0);
        set_csr(2'd0, 1'b0, 1'b0);
        lookup("user_s_page", l0_addr(base, 1), load, 1'b0, 1'b0);
        set_csr(2'd1, 1'b0, 1'b0);
        lookup("sup_u_page", l0_addr(base, 2), load, 1'b0, 1'b0);
        set_csr(2'd1, 1'b1, 1'b0);
        lookup("sup_u_page_sum", l0_addr(base, 2), load, 1'b0, 1'b0);
        lookup("x_only_load", l0_addr(base, 3), load, 1'b0, 1'b0);
        set_csr(2'd1, 1'b0, 1'b1);
        lookup("x_only_load_mxr", l0_addr(base, 3), load, 1'b0, 1'b0);
        lookup("x_only_fetch", l0_addr(base, 3), fetch, 1'b0, 1'b0);
        set_csr(2'd1, 1'b0, 1'b0);

        base = rand_bits(32);
        for (int i = 0; i < line_ptes; i++) line[i] = pointer_pte();
        refill_line(2'b10, base, line);
        lookup("l1_pointer", l1_addr(base, 1), store, 1'b0, 1'b0);
        lookup("refill_collide", l1_addr(base, 3), load, 1'b0, 1'b1);

        // two level 0 lines in different sets, then fences.
        base = rand_bits(32);
        other = base ^ 32'h0002_0000;
        refill_line(2'b01, base, leaf_line(1'b0));
        refill_line(2'b01, other, leaf_line(1'b0));
        lookup("before_fence", l0_addr(base, 0), load, 1'b0, 1'b0);
        lookup("before_fence", l0_addr(other, 0), load, 1'b0, 1'b0);
        run_fence(1'b0, base);
        lookup("fenced_addr", l0_addr(base, 1), load, 1'b0, 1'b0);
        lookup("other_set", l0_addr(other, 2), load, 1'b0, 1'b0);
        run_fence(1'b1, rand_bits(32));
        foreach (bases[i]) begin
            lookup("after_fence_all", bases[i], load, 1'b0, 1'b0);
        end

        repeat (4) @(posedge clk);
        $display("l2_tlb_tb finished with %0d errors", errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* project.f */
design/l2_tlb_pkg.sv
design/tlb_sram.sv
design/tlb_perm_check.sv
design/tlb_paddr_gen.sv
design/tlb_page.sv
design/l2_tlb.sv
dv/l2_tlb_tb.sv
